//--- hdl/tiny_core_params.svh
/*
  Shared constants for the tiny_core RV32 subset core.
  Included by every file that needs a width, the reset PC or an opcode.
*/
`ifndef TINY_CORE_PARAMS_SVH
`define TINY_CORE_PARAMS_SVH

// Data and address width
`define TC_XLEN      32
// Architectural register count
`define TC_NUM_REGS  32
// First fetch address after reset
`define TC_RESET_PC  32'h0000_0000

// ------------------------------------------------------------
// Major opcodes, bits [6:0] of the instruction word
// ------------------------------------------------------------
`define TC_OP_REG    7'b0110011
`define TC_OP_IMM    7'b0010011
`define TC_OP_LOAD   7'b0000011
`define TC_OP_STORE  7'b0100011
`define TC_OP_BRANCH 7'b1100011

`endif

//--- hdl/tiny_core_pkg.sv
/*
  Types shared by the core units and the testbench.
  Instruction formats, decoded op, memory port and trace structs.
*/
`default_nettype none

`include "tiny_core_params.svh"

package tiny_core_pkg;

  // ------------------------------------------------------------
  // Instruction word, one word seen in four formats
  // ------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } inst_u;

  // ------------------------------------------------------------
  // Decoded op
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    ADD,
    SUB,
    PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`TC_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                use_imm;
    logic                reg_wen;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
  } dec_op_t;

  // ------------------------------------------------------------
  // Memory ports and retirement trace
  // ------------------------------------------------------------
  typedef struct packed {
    logic                val;
    logic                wen;
    logic [`TC_XLEN-1:0] addr;
    logic [`TC_XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                val;
    logic [`TC_XLEN-1:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic                val;
    logic [`TC_XLEN-1:0] pc;
    logic [4:0]          waddr;
    logic [`TC_XLEN-1:0] wdata;
    logic                wen;
  } inst_trace_t;

endpackage

`default_nettype wire

//--- hdl/fetch_unit.sv
/*
  PC and instruction register of tiny_core.
  Fetches one word, then holds it until the execute stage retires it.
*/
`timescale 1ns/10ps
`default_nettype none

`include "tiny_core_params.svh"

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  output tiny_core_pkg::mem_req_t  imem_req,
  input  tiny_core_pkg::mem_resp_t imem_resp,
  input  logic                     retire,
  input  logic [31:0]              next_pc,
  output tiny_core_pkg::inst_u     inst,
  output logic [31:0]              pc,
  output logic                     inst_valid
);

  // Waiting for the fetch response, or for retirement
  typedef enum logic {
    S_FETCH,
    S_EXEC
  } fetch_state_e;

  fetch_state_e state;
  logic         req_val;
  // Request issued, response not yet back
  logic         req_pend;

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_FETCH;
      req_val  <= 1'b0;
      req_pend <= 1'b0;
      pc       <= `TC_RESET_PC;
    end else begin
      // Request is a single-cycle pulse
      req_val <= 1'b0;
      case (state)
        S_FETCH: begin
          // First fetch out of reset
          if (!req_pend) begin
            req_val  <= 1'b1;
            req_pend <= 1'b1;
          end
          if (imem_resp.val) begin
            state    <= S_EXEC;
            req_pend <= 1'b0;
          end
        end
        S_EXEC: begin
          // Next fetch goes out the cycle after retirement
          if (retire) begin
            pc       <= next_pc;
            req_val  <= 1'b1;
            req_pend <= 1'b1;
            state    <= S_FETCH;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (state == S_FETCH && imem_resp.val) begin
      inst <= imem_resp.rdata;
    end
  end

  // Read-only port
  always_comb begin
    imem_req.val   = req_val;
    imem_req.wen   = 1'b0;
    imem_req.addr  = pc;
    imem_req.wdata = '0;
  end

  assign inst_valid = (state == S_EXEC);

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
/*
  Combinational decoder for the supported RV32I subset.
  Picks the format view by opcode; unknown opcodes decode as a no-op.
*/
`timescale 1ns/10ps
`default_nettype none

`include "tiny_core_params.svh"

module decode_unit (
  input  tiny_core_pkg::inst_u   inst,
  output tiny_core_pkg::dec_op_t dec
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;

  // ------------------------------------------------------------
  // Sign-extended immediates
  // ------------------------------------------------------------
  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  // Branch offsets are in units of two bytes
  assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                  inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_comb begin
    // Register fields sit in the same place in every format
    dec.rs1       = inst.r_fmt.rs1;
    dec.rs2       = inst.r_fmt.rs2;
    dec.rd        = inst.r_fmt.rd;
    dec.imm       = '0;
    dec.alu_op    = tiny_core_pkg::PASS_B;
    dec.use_imm   = 1'b0;
    dec.reg_wen   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.is_branch = 1'b0;

    case (inst.r_fmt.opcode)
      `TC_OP_REG: begin
        // funct7 bit 5 tells SUB from ADD
        dec.alu_op  = inst.r_fmt.funct7[5] ? tiny_core_pkg::SUB : tiny_core_pkg::ADD;
        dec.reg_wen = 1'b1;
      end
      `TC_OP_IMM: begin
        dec.imm     = imm_i;
        dec.alu_op  = tiny_core_pkg::ADD;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
      end
      `TC_OP_LOAD: begin
        dec.imm     = imm_i;
        dec.alu_op  = tiny_core_pkg::ADD;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        dec.is_load = 1'b1;
      end
      `TC_OP_STORE: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      `TC_OP_BRANCH: begin
        // Only BNE is implemented
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      default: begin
        // No-op, all flags stay low
        dec.imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
/*
  Architectural register file, two read ports and one write port.
  Reads are combinational, the write lands on the clock edge.
*/
`timescale 1ns/10ps
`default_nettype none

`include "tiny_core_params.svh"

module reg_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [`TC_XLEN-1:0] regs [`TC_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `TC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      // x0 is never written, so it reads zero
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
/*
  Execute stage: ALU, BNE resolution, data access and writeback.
  Retire, register write and trace all come from one retire term.
*/
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       inst_valid,
  input  logic [31:0]                pc,
  input  tiny_core_pkg::dec_op_t     dec,
  input  logic [31:0]                rs1_data,
  input  logic [31:0]                rs2_data,
  output logic                       rf_wen,
  output logic [4:0]                 rf_waddr,
  output logic [31:0]                rf_wdata,
  output tiny_core_pkg::mem_req_t    dmem_req,
  input  tiny_core_pkg::mem_resp_t   dmem_resp,
  output logic                       retire,
  output logic [31:0]                next_pc,
  output tiny_core_pkg::inst_trace_t inst_trace
);

  logic        mem_op;
  // Data request issued, waiting for its response
  logic        mem_busy;
  logic [31:0] alu_b;
  logic [31:0] alu_res;
  logic [31:0] wb_data;

  assign mem_op = dec.is_load | dec.is_store;

  // ------------------------------------------------------------
  // ALU and branch
  // ------------------------------------------------------------
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    case (dec.alu_op)
      tiny_core_pkg::ADD: alu_res = rs1_data + alu_b;
      tiny_core_pkg::SUB: alu_res = rs1_data - alu_b;
      default:            alu_res = alu_b;
    endcase
  end

  // BNE, taken when the sources differ
  assign next_pc = (dec.is_branch && rs1_data != rs2_data) ? pc + dec.imm : pc + 32'd4;

  // ------------------------------------------------------------
  // Data memory
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_busy <= 1'b0;
    end else if (!mem_busy) begin
      mem_busy <= inst_valid & mem_op;
    end else if (dmem_resp.val) begin
      mem_busy <= 1'b0;
    end
  end

  // Pulses in the first cycle of a load or store
  always_comb begin
    dmem_req.val   = inst_valid & mem_op & ~mem_busy;
    dmem_req.wen   = dec.is_store;
    dmem_req.addr  = rs1_data + dec.imm;
    dmem_req.wdata = rs2_data;
  end

  // ------------------------------------------------------------
  // Retire and writeback
  // ------------------------------------------------------------
  // Memory ops finish on the response, the rest at once
  assign retire  = inst_valid & (mem_op ? (mem_busy & dmem_resp.val) : 1'b1);
  assign wb_data = dec.is_load ? dmem_resp.rdata : alu_res;

  // x0 counts as no write
  assign rf_wen   = retire & dec.reg_wen & (dec.rd != 5'd0);
  assign rf_waddr = rf_wen ? dec.rd : 5'd0;
  assign rf_wdata = wb_data;

  always_comb begin
    inst_trace.val   = retire;
    inst_trace.pc    = pc;
    inst_trace.waddr = rf_waddr;
    inst_trace.wdata = rf_wen ? wb_data : 32'd0;
    inst_trace.wen   = rf_wen;
  end

endmodule

`default_nettype wire

//--- hdl/tiny_core.sv
/*
  Top level of the multicycle RV32 subset core.
  Connects fetch, decode, register file and execute to the memory and trace ports.
*/
`timescale 1ns/10ps
`default_nettype none

module tiny_core (
  input  logic                       clk,
  input  logic                       rst_n,
  output tiny_core_pkg::mem_req_t    imem_req,
  input  tiny_core_pkg::mem_resp_t   imem_resp,
  output tiny_core_pkg::mem_req_t    dmem_req,
  input  tiny_core_pkg::mem_resp_t   dmem_resp,
  output tiny_core_pkg::inst_trace_t inst_trace
);

  // Fetch to decode and execute
  tiny_core_pkg::inst_u   inst;
  logic [31:0]            pc;
  logic                   inst_valid;
  tiny_core_pkg::dec_op_t dec;

  // Register file
  logic [31:0]            rs1_data;
  logic [31:0]            rs2_data;
  logic                   rf_wen;
  logic [4:0]             rf_waddr;
  logic [31:0]            rf_wdata;

  // Execute back to fetch
  logic                   retire;
  logic [31:0]            next_pc;

  fetch_unit fetch0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_req   (imem_req),
    .imem_resp  (imem_resp),
    .retire     (retire),
    .next_pc    (next_pc),
    .inst       (inst),
    .pc         (pc),
    .inst_valid (inst_valid)
  );

  decode_unit decode0 (
    .inst (inst),
    .dec  (dec)
  );

  reg_file rf0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  exec_unit exec0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .pc         (pc),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .dmem_req   (dmem_req),
    .dmem_resp  (dmem_resp),
    .retire     (retire),
    .next_pc    (next_pc),
    .inst_trace (inst_trace)
  );

endmodule

`default_nettype wire

//--- verification/dual_port_mem.sv
/*
  Testbench memory shared by an instruction port and a data port.
  Each request gets one response 1 to 4 cycles later, with a random latency.
  Preload, peek and clear give zero-time access from the testbench.
*/
`timescale 1ns/10ps
`default_nettype none

module dual_port_mem (
  input  logic                     clk,
  input  logic                     rst_n,
  input  tiny_core_pkg::mem_req_t  imem_req,
  output tiny_core_pkg::mem_resp_t imem_resp,
  input  tiny_core_pkg::mem_req_t  dmem_req,
  output tiny_core_pkg::mem_resp_t dmem_resp
);

  // 4 KB, word addressed by addr[11:2]
  logic [31:0] words [1024];

  // Port 0 fetches, port 1 loads and stores
  tiny_core_pkg::mem_req_t  req  [2];
  tiny_core_pkg::mem_req_t  held [2];
  tiny_core_pkg::mem_resp_t resp [2];
  // Cycles left before a held request is answered
  int                       cnt  [2];

  assign req[0]    = imem_req;
  assign req[1]    = dmem_req;
  assign imem_resp = resp[0];
  assign dmem_resp = resp[1];

  // Read the old word, then write if it is a store
  task automatic serve(input tiny_core_pkg::mem_req_t r,
                       output tiny_core_pkg::mem_resp_t o);
    o.val   = 1'b1;
    o.rdata = words[r.addr[11:2]];
    if (r.wen) begin
      words[r.addr[11:2]] = r.wdata;
    end
  endtask

  // ------------------------------------------------------------
  // Response sequencing, one request in flight per port
  // ------------------------------------------------------------
  always @(posedge clk) begin
    int                       lat;
    tiny_core_pkg::mem_resp_t r;
    for (int p = 0; p < 2; p++) begin
      if (!rst_n) begin
        cnt[p]  <= 0;
        resp[p] <= '0;
      end else begin
        // Response strobe lasts one cycle
        resp[p].val <= 1'b0;
        if (req[p].val) begin
          // Extra wait beyond the minimum of one cycle
          lat = $urandom_range(3, 0);
          if (lat == 0) begin
            serve(req[p], r);
            resp[p] <= r;
          end else begin
            held[p] <= req[p];
            cnt[p]  <= lat;
          end
        end else if (cnt[p] != 0) begin
          cnt[p] <= cnt[p] - 1;
          if (cnt[p] == 1) begin
            serve(held[p], r);
            resp[p] <= r;
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Zero-time access for the testbench
  // ------------------------------------------------------------
  task automatic clear_words();
    for (int i = 0; i < 1024; i++) begin
      words[i] = '0;
    end
  endtask

  task automatic preload(input logic [31:0] addr, input logic [31:0] data);
    words[addr[11:2]] = data;
  endtask

  task automatic peek(input logic [31:0] addr, output logic [31:0] data);
    data = words[addr[11:2]];
  endtask

endmodule

`default_nettype wire

//--- verification/tiny_core_tb.sv
/*
  Directed tests for tiny_core covering reset, arithmetic, memory, branch,
  unknown opcode and a random program. Every retired instruction on the
  trace port is compared with a reference model.
*/
`timescale 1ns/10ps
`default_nettype none

`include "tiny_core_params.svh"

module tiny_core_tb;

  // Cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic clk   = 1'b0;
  logic rst_n = 1'b0;

  tiny_core_pkg::mem_req_t    imem_req;
  tiny_core_pkg::mem_resp_t   imem_resp;
  tiny_core_pkg::mem_req_t    dmem_req;
  tiny_core_pkg::mem_resp_t   dmem_resp;
  tiny_core_pkg::inst_trace_t inst_trace;

  int tests_run    = 0;
  int tests_failed = 0;
  int total_errors = 0;
  int test_errors  = 0;

  // Program image and reference model state
  logic [31:0] prog [$];
  logic [31:0] model_mem [int];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;

  always #4 clk = ~clk;

  tiny_core dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_req   (imem_req),
    .imem_resp  (imem_resp),
    .dmem_req   (dmem_req),
    .dmem_resp  (dmem_resp),
    .inst_trace (inst_trace)
  );

  dual_port_mem mem0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_req  (imem_req),
    .imem_resp (imem_resp),
    .dmem_req  (dmem_req),
    .dmem_resp (dmem_resp)
  );

  // ------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
    return {funct7, rs2, rs1, 3'b000, rd, `TC_OP_REG};
  endfunction

  // ADDI or LW with funct3 010 for a word load
  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [6:0] opcode, input logic [4:0] rd);
    logic [2:0] funct3;
    funct3 = (opcode == `TC_OP_LOAD) ? 3'b010 : 3'b000;
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `TC_OP_STORE};
  endfunction

  // BNE with a byte offset whose bit 0 is dropped
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], `TC_OP_BRANCH};
  endfunction

  // ------------------------------------------------------------
  // Reference model stepping one instruction per call
  // ------------------------------------------------------------
  task automatic model_step(output tiny_core_pkg::inst_trace_t exp);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] res;
    logic [31:0] next;
    logic [4:0]  rd;
    logic        wr;
    int          idx;
    idx   = int'(model_pc[31:2]);
    w     = model_mem.exists(idx) ? model_mem[idx] : 32'd0;
    rd    = w[11:7];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    wr    = 1'b0;
    res   = 32'd0;
    next  = model_pc + 32'd4;
    case (w[6:0])
      `TC_OP_REG: begin
        wr  = 1'b1;
        res = w[30] ? a - b : a + b;
      end
      `TC_OP_IMM: begin
        wr  = 1'b1;
        res = a + imm_i;
      end
      `TC_OP_LOAD: begin
        wr  = 1'b1;
        idx = int'((a + imm_i) >> 2);
        res = model_mem.exists(idx) ? model_mem[idx] : 32'd0;
      end
      `TC_OP_STORE: begin
        model_mem[int'((a + imm_s) >> 2)] = b;
      end
      `TC_OP_BRANCH: begin
        if (a != b) begin
          next = model_pc + imm_b;
        end
      end
      default: begin
        // Anything else retires without effect
        wr = 1'b0;
      end
    endcase
    exp.val   = 1'b1;
    exp.pc    = model_pc;
    exp.wen   = wr && (rd != 5'd0);
    exp.waddr = exp.wen ? rd : 5'd0;
    exp.wdata = exp.wen ? res : 32'd0;
    if (exp.wen) begin
      model_regs[rd] = res;
    end
    model_pc = next;
  endtask

  // ------------------------------------------------------------
  // Reset, load and trace checking
  // ------------------------------------------------------------
  // Reset low for 5 cycles while memory and model are loaded
  task automatic load_and_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    mem0.clear_words();
    model_mem.delete();
    foreach (prog[i]) begin
      mem0.preload(32'(i * 4), prog[i]);
      model_mem[i] = prog[i];
    end
    foreach (model_regs[r]) begin
      model_regs[r] = '0;
    end
    model_pc = `TC_RESET_PC;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_trace(output tiny_core_pkg::inst_trace_t t, output bit ok);
    ok = 1'b0;
    t  = '0;
    for (int n = 0; n < TIMEOUT && !ok; n++) begin
      @(negedge clk);
      if (inst_trace.val) begin
        t  = inst_trace;
        ok = 1'b1;
      end
    end
  endtask

  task automatic run_and_check(input int count);
    tiny_core_pkg::inst_trace_t exp;
    tiny_core_pkg::inst_trace_t got;
    bit                         ok;
    for (int k = 0; k < count; k++) begin
      model_step(exp);
      wait_trace(got, ok);
      if (!ok) begin
        $display("timeout: instruction %0d did not retire within %0d cycles", k, TIMEOUT);
        test_errors++;
        break;
      end
      assert (got == exp) else begin
        $write("error at %0t: retire %0d pc %h waddr %0d wdata %h wen %b", $time, k,
               got.pc, got.waddr, got.wdata, got.wen);
        $display(", expected pc %h waddr %0d wdata %h wen %b",
                 exp.pc, exp.waddr, exp.wdata, exp.wen);
        test_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic reset_test();
    bit seen_req;
    bit seen_resp;
    prog.delete();
    prog.push_back(i_type(12'd42, 5'd0, `TC_OP_IMM, 5'd1));
    load_and_reset();
    seen_req  = 1'b0;
    seen_resp = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen_resp; n++) begin
      @(negedge clk);
      // Quiet until the first instruction arrives
      assert (!inst_trace.val && !dmem_req.val) else begin
        $display("error at %0t: trace or data request before first fetch", $time);
        test_errors++;
      end
      if (imem_req.val && !seen_req) begin
        seen_req = 1'b1;
        assert (imem_req.addr == `TC_RESET_PC) else begin
          $display("error at %0t: first fetch address %h", $time, imem_req.addr);
          test_errors++;
        end
      end
      seen_resp = imem_resp.val;
    end
    if (!seen_resp) begin
      $display("timeout: no instruction fetch completed after reset");
      test_errors++;
    end else begin
      run_and_check(1);
    end
    finish_test("reset");
  endtask

  task automatic arith_test();
    prog.delete();
    prog.push_back(i_type(12'd7, 5'd0, `TC_OP_IMM, 5'd1));
    prog.push_back(i_type(12'hffd, 5'd0, `TC_OP_IMM, 5'd2));
    prog.push_back(r_type(7'b0000000, 5'd2, 5'd1, 5'd3));
    prog.push_back(r_type(7'b0100000, 5'd2, 5'd1, 5'd4));
    // Writes to x0 report no write
    prog.push_back(i_type(12'd5, 5'd1, `TC_OP_IMM, 5'd0));
    prog.push_back(r_type(7'b0000000, 5'd1, 5'd0, 5'd5));
    prog.push_back(r_type(7'b0100000, 5'd4, 5'd3, 5'd0));
    load_and_reset();
    run_and_check(7);
    finish_test("arithmetic");
  endtask

  task automatic memory_test();
    logic [31:0] word;
    logic [31:0] addr;
    prog.delete();
    prog.push_back(i_type(12'h123, 5'd0, `TC_OP_IMM, 5'd1));
    prog.push_back(i_type(12'hffb, 5'd0, `TC_OP_IMM, 5'd2));
    prog.push_back(s_type(12'h400, 5'd1, 5'd0));
    prog.push_back(s_type(12'h404, 5'd2, 5'd0));
    prog.push_back(i_type(12'h400, 5'd0, `TC_OP_LOAD, 5'd3));
    prog.push_back(i_type(12'h404, 5'd0, `TC_OP_LOAD, 5'd4));
    // Base register plus offset overwrites the second word
    prog.push_back(i_type(12'h400, 5'd0, `TC_OP_IMM, 5'd5));
    prog.push_back(s_type(12'd4, 5'd3, 5'd5));
    prog.push_back(i_type(12'd4, 5'd5, `TC_OP_LOAD, 5'd6));
    load_and_reset();
    run_and_check(9);
    for (int k = 0; k < 2; k++) begin
      addr = 32'h400 + 32'(k * 4);
      mem0.peek(addr, word);
      assert (word == model_mem[256 + k]) else begin
        $display("error at %0t: memory at %h holds %h, expected %h", $time, addr, word,
                 model_mem[256 + k]);
        test_errors++;
      end
    end
    finish_test("memory");
  endtask

  task automatic branch_test();
    prog.delete();
    prog.push_back(i_type(12'd3, 5'd0, `TC_OP_IMM, 5'd1));
    prog.push_back(i_type(12'd0, 5'd0, `TC_OP_IMM, 5'd2));
    // Loop body at 0x8 runs three times
    prog.push_back(i_type(12'd1, 5'd2, `TC_OP_IMM, 5'd2));
    prog.push_back(i_type(12'hfff, 5'd1, `TC_OP_IMM, 5'd1));
    prog.push_back(b_type(13'h1ff8, 5'd1, 5'd0));
    prog.push_back(i_type(12'd0, 5'd2, `TC_OP_IMM, 5'd3));
    load_and_reset();
    run_and_check(12);
    finish_test("branch");
  endtask

  task automatic nop_test();
    prog.delete();
    prog.push_back(i_type(12'd9, 5'd0, `TC_OP_IMM, 5'd7));
    // Looks like ADDI x7 but with an unused opcode
    prog.push_back({12'd5, 5'd1, 3'b000, 5'd7, 7'b1111111});
    prog.push_back(i_type(12'd1, 5'd7, `TC_OP_IMM, 5'd8));
    load_and_reset();
    run_and_check(3);
    finish_test("unknown opcode");
  endtask

  task automatic random_test();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] off;
    int          kind;
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      rd   = 5'($urandom_range(7, 0));
      rs1  = 5'($urandom_range(7, 0));
      rs2  = 5'($urandom_range(7, 0));
      // Data words in 0x400 to 0x4fc stay clear of the program
      off  = 12'h400 + 12'($urandom_range(63, 0) * 4);
      kind = $urandom_range(4, 0);
      case (kind)
        0: prog.push_back(i_type(12'($urandom), rs1, `TC_OP_IMM, rd));
        1: prog.push_back(r_type(7'b0000000, rs2, rs1, rd));
        2: prog.push_back(r_type(7'b0100000, rs2, rs1, rd));
        3: prog.push_back(s_type(off, rs2, 5'd0));
        default: prog.push_back(i_type(off, 5'd0, `TC_OP_LOAD, rd));
      endcase
    end
    load_and_reset();
    run_and_check(40);
    finish_test("random program");
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h03da23f8));
    reset_test();
    arith_test();
    memory_test();
    branch_test();
    nop_test();
    random_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tiny_core.f
+incdir+hdl
hdl/tiny_core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/tiny_core.sv
verification/dual_port_mem.sv
verification/tiny_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the tiny_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tiny_core.f --top-module tiny_core_tb \
    -o tiny_core_sim \
  && ./obj_dir/tiny_core_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
